//--- design/board_pkg.sv
`default_nettype none

package board_pkg;

	// --------------------
	// Reset timing
	// --------------------

	// Flash/codec reset hold after rst1 rises
	localparam int unsigned FLASH_RST_CYCLES = 128;

	// Further hold on the system reset, doubles as debounce
	localparam int unsigned SYS_RST_CYCLES = 1024;

	// Hold timer count, wide enough for the longer phase
	localparam int unsigned TIMER_W = 11;

	// --------------------
	// Activity LEDs
	// --------------------

	// Visible pulse length per low sample
	localparam int unsigned ACT_LED_CYCLES = 256;
	localparam int unsigned ACT_CNT_W = $clog2(ACT_LED_CYCLES + 1);

	// --------------------
	// GPIO
	// --------------------

	// 8 DIP switches over 5 buttons
	localparam int unsigned GPIO_IN_W = 13;
	localparam int unsigned GPIO_OUT_W = 14;

	// Output word, raw as written, fields as wired to the pins
	typedef union packed {
		logic [GPIO_OUT_W-1:0] raw;
		struct packed {
			logic [3:0] lcd_d;
			logic lcd_rw;
			logic lcd_rs;
			logic lcd_e;
			logic [4:0] btnled;
			logic [1:0] led;   // user LEDs, low end of the word
		} f;
	} gpio_out_t;

	// Reset sequencer states
	typedef enum logic [1:0] {HOLD, FLASH_WAIT, SYS_WAIT, RUN} seq_state_t;

endpackage

`default_nettype wire

//--- design/timer_if.sv
`timescale 1ns/10ps
`default_nettype none

interface timer_if
	import board_pkg::*;
();

	// Single-cycle load strobe and its count
	logic load;
	logic [TIMER_W-1:0] load_value;

	// Timer status back to the sequencer
	logic running;
	logic expired;

	// Reset sequencer side
	modport ctrl (
		output load, load_value,
		input running, expired
	);

	// Hold timer side
	modport timer (
		input load, load_value,
		output running, expired
	);

endinterface

`default_nettype wire

//--- design/hold_timer.sv
`timescale 1ns/10ps
`default_nettype none

module hold_timer
	import board_pkg::*;
(
	input wire logic sys_clk,
	input wire logic rst1,
	timer_if.timer t
);

	// Remaining cycles of the current phase
	logic [TIMER_W-1:0] count;

	// --------------------
	// Down-counter
	// --------------------
	// Load on the strobe edge, expired one edge after count hits 1
	// so the pulse lands load_value cycles after the strobe
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			count <= '0;
			t.running <= 1'b0;
			t.expired <= 1'b0;
		end else begin
			// Expired is a one-cycle pulse
			t.expired <= 1'b0;
			if (t.load) begin
				// Load also restarts a count in progress
				count <= t.load_value;
				t.running <= (t.load_value != '0);
				// Zero load expires at once
				t.expired <= (t.load_value == '0);
			end else if (t.running) begin
				count <= count - 1'b1;
				if (count == TIMER_W'(1)) begin
					t.running <= 1'b0;
					t.expired <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/reset_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer
	import board_pkg::*;
(
	input wire logic sys_clk,
	input wire logic rst1,
	timer_if.ctrl t,
	output logic flash_rst_n_o,
	output logic sys_rst_o
);

	seq_state_t state;

	// --------------------
	// Timer loads
	// --------------------
	// Loads are one short of the phase length
	// Timer expires on the edge the count ends, the FSM acts one edge later
	always_comb begin
		t.load = 1'b0;
		t.load_value = '0;
		case (state)
			HOLD: begin
				// rst1 back high, start the flash phase
				if (rst1) begin
					t.load = 1'b1;
					t.load_value = TIMER_W'(FLASH_RST_CYCLES - 1);
				end
			end
			FLASH_WAIT: begin
				// Chain straight into the debounce phase
				if (t.expired) begin
					t.load = 1'b1;
					t.load_value = TIMER_W'(SYS_RST_CYCLES - 1);
				end
			end
			default: begin
				t.load = 1'b0;
			end
		endcase
	end

	// --------------------
	// Sequencer FSM
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			// Any low sample restarts from the top
			state <= HOLD;
			flash_rst_n_o <= 1'b0;
			sys_rst_o <= 1'b1;
		end else begin
			case (state)
				HOLD: begin
					// rst1 high here, timer loaded this edge
					state <= FLASH_WAIT;
					flash_rst_n_o <= 1'b0;
					sys_rst_o <= 1'b1;
				end
				FLASH_WAIT: begin
					if (t.expired) begin
						// Flash and codec out of reset first
						flash_rst_n_o <= 1'b1;
						state <= SYS_WAIT;
					end else if (!t.running) begin
						// Timer lost, sequence again
						state <= HOLD;
					end
				end
				SYS_WAIT: begin
					if (t.expired) begin
						sys_rst_o <= 1'b0;
						state <= RUN;
					end else if (!t.running) begin
						state <= HOLD;
						flash_rst_n_o <= 1'b0;
					end
				end
				RUN: begin
					// Stays here until rst1 drops
					state <= RUN;
				end
				default: begin
					state <= HOLD;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/activity_stretcher.sv
`timescale 1ns/10ps
`default_nettype none

module activity_stretcher
	import board_pkg::*;
(
	input wire logic sys_clk,
	input wire logic rst1,
	input wire logic line_i,
	output logic led_o
);

	// Cycles left in the visible pulse
	logic [ACT_CNT_W-1:0] count;

	// --------------------
	// Stretch counter
	// --------------------
	// Serial line idles high, any low sample is a start or data bit
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			count <= '0;
		end else if (!line_i) begin
			// Retrigger on every low sample
			count <= ACT_CNT_W'(ACT_LED_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Registered so the LED pin is glitch free
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			led_o <= 1'b0;
		end else begin
			led_o <= (count != '0);
		end
	end

endmodule

`default_nettype wire

//--- design/gpio_port.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_port
	import board_pkg::*;
(
	input wire logic sys_clk,
	input wire logic rst1,
	input wire logic sys_rst_i,
	input wire logic gpio_we_i,
	input wire logic [GPIO_OUT_W-1:0] gpio_dat_i,
	input wire logic [GPIO_IN_W-1:0] gpio_in_i,
	output logic [GPIO_IN_W-1:0] gpio_in_o,
	output logic gpio_irq_o,
	output gpio_out_t gpio_out_o
);

	// First synchronizer stage, may go metastable
	logic [GPIO_IN_W-1:0] in_meta;
	// Last synchronized value, for change detect
	logic [GPIO_IN_W-1:0] in_prev;

	// --------------------
	// Output register
	// --------------------
	// Written whole through the raw view
	// Pins stay low until the system is out of reset
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			gpio_out_o.raw <= '0;
		end else if (sys_rst_i) begin
			// Strobes ignored while in system reset
			gpio_out_o.raw <= '0;
		end else if (gpio_we_i) begin
			gpio_out_o.raw <= gpio_dat_i;
		end
	end

	// --------------------
	// Input synchronizer
	// --------------------
	// Buttons and DIP switches are asynchronous to sys_clk
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			in_meta <= '0;
			gpio_in_o <= '0;
		end else begin
			in_meta <= gpio_in_i;
			gpio_in_o <= in_meta;
		end
	end

	// --------------------
	// Change interrupt
	// --------------------
	// One pulse per change of the synchronized word
	// Two sync stages plus this compare, so 3 cycles from the pin
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			in_prev <= '0;
			gpio_irq_o <= 1'b0;
		end else begin
			in_prev <= gpio_in_o;
			gpio_irq_o <= (gpio_in_o != in_prev);
		end
	end

endmodule

`default_nettype wire

//--- design/board_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module board_ctrl_top
	import board_pkg::*;
(
	input wire logic sys_clk,
	input wire logic rst1,

	// UART lines, both monitored only
	input wire logic uart_rxd_i,
	input wire logic uart_txd_i,

	// Board inputs
	input wire logic [4:0] btn_i,
	input wire logic [7:0] dipsw_i,

	// GPIO write port and status
	input wire logic gpio_we_i,
	input wire logic [GPIO_OUT_W-1:0] gpio_dat_i,
	output logic [GPIO_IN_W-1:0] gpio_in_o,
	output logic gpio_irq_o,

	// Resets
	output logic flash_rst_n_o,
	output logic sys_rst_o,

	// LEDs and LCD
	output logic [3:0] led_o,
	output logic [4:0] btnled_o,
	output logic lcd_e_o,
	output logic lcd_rs_o,
	output logic lcd_rw_o,
	output logic [3:0] lcd_d_o
);

	// --------------------
	// Reset sequencing
	// --------------------
	timer_if tmr_if ();

	hold_timer u_hold_timer (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.t(tmr_if.timer)
	);

	reset_sequencer u_reset_sequencer (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.t(tmr_if.ctrl),
		.flash_rst_n_o(flash_rst_n_o),
		.sys_rst_o(sys_rst_o)
	);

	// --------------------
	// UART activity
	// --------------------
	logic tx_led;
	logic rx_led;

	activity_stretcher tx_act (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.line_i(uart_txd_i),
		.led_o(tx_led)
	);

	activity_stretcher rx_act (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.line_i(uart_rxd_i),
		.led_o(rx_led)
	);

	// --------------------
	// GPIO
	// --------------------
	gpio_out_t gpio_out;

	// DIP switches high, buttons low
	gpio_port u_gpio_port (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.sys_rst_i(sys_rst_o),
		.gpio_we_i(gpio_we_i),
		.gpio_dat_i(gpio_dat_i),
		.gpio_in_i({dipsw_i, btn_i}),
		.gpio_in_o(gpio_in_o),
		.gpio_irq_o(gpio_irq_o),
		.gpio_out_o(gpio_out)
	);

	// LED0 tx, LED1 rx, upper two from software
	assign led_o = {gpio_out.f.led, rx_led, tx_led};
	assign btnled_o = gpio_out.f.btnled;

	// LCD pins straight from the field view
	assign lcd_e_o = gpio_out.f.lcd_e;
	assign lcd_rs_o = gpio_out.f.lcd_rs;
	assign lcd_rw_o = gpio_out.f.lcd_rw;
	assign lcd_d_o = gpio_out.f.lcd_d;

endmodule

`default_nettype wire

//--- sim/tb_board_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_board_ctrl
	import board_pkg::*;
();

	localparam int TABLE_LEN = 16;
	localparam int TIMEOUT_CYCLES = 2 * (FLASH_RST_CYCLES + SYS_RST_CYCLES
		+ ACT_LED_CYCLES * 4 + TABLE_LEN * 10);
	localparam int TX_LED = 0;
	localparam int RX_LED = 1;

	logic sys_clk = 1'b0;
	logic rst1;
	logic uart_rxd_i;
	logic uart_txd_i;
	logic [4:0] btn_i;
	logic [7:0] dipsw_i;
	logic gpio_we_i;
	logic [GPIO_OUT_W-1:0] gpio_dat_i;
	logic [GPIO_IN_W-1:0] gpio_in_o;
	logic gpio_irq_o;
	logic flash_rst_n_o;
	logic sys_rst_o;
	logic [3:0] led_o;
	logic [4:0] btnled_o;
	logic lcd_e_o;
	logic lcd_rs_o;
	logic lcd_rw_o;
	logic [3:0] lcd_d_o;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// GPIO table of write words and expected pin fields
	logic [GPIO_OUT_W-1:0] tbl_dat [TABLE_LEN];
	logic [1:0] tbl_led [TABLE_LEN];
	logic [4:0] tbl_btn [TABLE_LEN];
	logic [2:0] tbl_ctl [TABLE_LEN];   // {rw, rs, e}
	logic [3:0] tbl_lcd_d [TABLE_LEN];

	board_ctrl_top DUT (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.uart_rxd_i(uart_rxd_i),
		.uart_txd_i(uart_txd_i),
		.btn_i(btn_i),
		.dipsw_i(dipsw_i),
		.gpio_we_i(gpio_we_i),
		.gpio_dat_i(gpio_dat_i),
		.gpio_in_o(gpio_in_o),
		.gpio_irq_o(gpio_irq_o),
		.flash_rst_n_o(flash_rst_n_o),
		.sys_rst_o(sys_rst_o),
		.led_o(led_o),
		.btnled_o(btnled_o),
		.lcd_e_o(lcd_e_o),
		.lcd_rs_o(lcd_rs_o),
		.lcd_rw_o(lcd_rw_o),
		.lcd_d_o(lcd_d_o)
	);

	// 100 ns clock
	always #50 sys_clk = ~sys_clk;

	// --------------------
	// Run limit
	// --------------------
	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// Exact compare so X and Z count as wrong
	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		checks++;
		if (exp_v !== act_v) begin
			errors++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, exp_v, act_v);
		end
	endtask

	// Software pins packed back into the field layout
	function automatic logic [GPIO_OUT_W-1:0] gpio_pins();
		return {lcd_d_o, lcd_rw_o, lcd_rs_o, lcd_e_o, btnled_o, led_o[3:2]};
	endfunction

	task automatic set_entry(input int i, input logic [GPIO_OUT_W-1:0] dat,
		input logic [1:0] led, input logic [4:0] btn, input logic [2:0] ctl,
		input logic [3:0] d);
		tbl_dat[i] = dat;
		tbl_led[i] = led;
		tbl_btn[i] = btn;
		tbl_ctl[i] = ctl;
		tbl_lcd_d[i] = d;
	endtask

	task automatic load_table();
		logic [GPIO_OUT_W-1:0] w;
		// One field at a time and then mixed words
		set_entry(0, 14'h0000, 2'h0, 5'h00, 3'b000, 4'h0);
		set_entry(1, 14'h0003, 2'h3, 5'h00, 3'b000, 4'h0);
		set_entry(2, 14'h007C, 2'h0, 5'h1F, 3'b000, 4'h0);
		set_entry(3, 14'h0080, 2'h0, 5'h00, 3'b001, 4'h0);
		set_entry(4, 14'h0100, 2'h0, 5'h00, 3'b010, 4'h0);
		set_entry(5, 14'h0200, 2'h0, 5'h00, 3'b100, 4'h0);
		set_entry(6, 14'h3C00, 2'h0, 5'h00, 3'b000, 4'hF);
		set_entry(7, 14'h3FFF, 2'h3, 5'h1F, 3'b111, 4'hF);
		set_entry(8, 14'h2A55, 2'h1, 5'h15, 3'b100, 4'hA);
		// Random words split by the field layout
		for (int i = 9; i < TABLE_LEN; i++) begin
			w = GPIO_OUT_W'($urandom());
			set_entry(i, w, w[1:0], w[6:2], w[9:7], w[13:10]);
		end
	endtask

	task automatic check_pins(input string name, input int i);
		check_val($sformatf("%s[%0d] led", name, i), tbl_led[i], led_o[3:2]);
		check_val($sformatf("%s[%0d] btnled", name, i), tbl_btn[i], btnled_o);
		check_val($sformatf("%s[%0d] lcd ctl", name, i), tbl_ctl[i],
			{lcd_rw_o, lcd_rs_o, lcd_e_o});
		check_val($sformatf("%s[%0d] lcd_d", name, i), tbl_lcd_d[i], lcd_d_o);
	endtask

	// --------------------
	// Reset release timing
	// --------------------
	// Called on a falling edge
	// idx counts rising edges from the first high sample
	task automatic release_and_measure(input string name);
		int idx;
		int flash_idx;
		int sys_idx;
		logic pins_bad;
		idx = 0;
		flash_idx = -1;
		sys_idx = -1;
		pins_bad = 1'b0;
		rst1 = 1'b1;
		while (sys_idx < 0 && idx <= FLASH_RST_CYCLES + SYS_RST_CYCLES + 16) begin
			@(negedge sys_clk);
			if (flash_idx < 0 && flash_rst_n_o)
				flash_idx = idx;
			if (sys_idx < 0 && !sys_rst_o)
				sys_idx = idx;
			// Pins stay low through system reset even with a strobe
			if (!pins_bad && gpio_pins() !== '0) begin
				pins_bad = 1'b1;
				errors++;
				$display("[ERROR] %s gpio pins: expected 0, actual %0h", name, gpio_pins());
			end
			gpio_we_i = (idx == 20);
			gpio_dat_i = '1;
			idx++;
		end
		gpio_we_i = 1'b0;
		if (sys_idx < 0) begin
			errors++;
			$display("%s: system reset was never released", name);
		end else begin
			check_val({name, " flash_rst_n edge"}, FLASH_RST_CYCLES, flash_idx);
			check_val({name, " sys_rst edge"}, FLASH_RST_CYCLES + SYS_RST_CYCLES, sys_idx);
		end
	endtask

	task automatic debounce_test();
		int n;
		// Back to HOLD from RUN
		rst1 = 1'b0;
		@(negedge sys_clk);
		rst1 = 1'b1;
		n = 0;
		while (!flash_rst_n_o && n <= FLASH_RST_CYCLES + 8) begin
			@(negedge sys_clk);
			n++;
		end
		if (flash_rst_n_o !== 1'b1) begin
			errors++;
			$display("Flash reset was not released before the debounce pulse");
		end
		// Well inside SYS_WAIT
		repeat (300) @(negedge sys_clk);
		check_val("sys_wait sys_rst", 1, sys_rst_o);
		rst1 = 1'b0;
		@(negedge sys_clk);
		check_val("debounce flash_rst_n", 0, flash_rst_n_o);
		check_val("debounce sys_rst", 1, sys_rst_o);
		release_and_measure("debounce_restart");
	endtask

	// --------------------
	// Input change
	// --------------------
	task automatic input_change_test();
		logic [GPIO_IN_W-1:0] word;
		int bitn;
		int pulses;
		int pulse_at;
		pulses = 0;
		for (int n = 0; n < 8; n++) begin
			@(negedge sys_clk);
			if (gpio_irq_o)
				pulses++;
		end
		check_val("irq steady", 0, pulses);
		word = {dipsw_i, btn_i};
		for (int k = 0; k < 4; k++) begin
			bitn = $urandom_range(GPIO_IN_W - 1, 0);
			word[bitn] = ~word[bitn];
			{dipsw_i, btn_i} = word;
			pulses = 0;
			pulse_at = -1;
			for (int n = 1; n <= 6; n++) begin
				@(negedge sys_clk);
				if (gpio_irq_o) begin
					pulses++;
					pulse_at = n;
				end
			end
			check_val($sformatf("irq count bit %0d", bitn), 1, pulses);
			check_val($sformatf("irq delay bit %0d", bitn), 3, pulse_at);
			check_val($sformatf("gpio_in bit %0d", bitn), word, gpio_in_o);
		end
	endtask

	// --------------------
	// Activity LEDs
	// --------------------
	task automatic drive_line(input int sel, input logic val);
		if (sel == RX_LED)
			uart_rxd_i = val;
		else
			uart_txd_i = val;
	endtask

	// gap 0 gives a single pulse
	// Otherwise a second pulse follows gap cycles after the first
	task automatic activity_test(input string name, input int sel, input int gap);
		logic [1:0] exp_led;
		logic on1;
		logic on2;
		logic bad;
		bad = 1'b0;
		drive_line(sel, 1'b0);
		for (int n = 1; n <= gap + ACT_LED_CYCLES + 4; n++) begin
			@(negedge sys_clk);
			// On from the second edge for ACT_LED_CYCLES edges
			on1 = (n >= 2) && (n <= ACT_LED_CYCLES + 1);
			on2 = (gap > 0) && (n - gap >= 2) && (n - gap <= ACT_LED_CYCLES + 1);
			exp_led = 2'b00;
			exp_led[sel] = on1 || on2;
			checks++;
			if (!bad && led_o[1:0] !== exp_led) begin
				bad = 1'b1;
				errors++;
				$display("[ERROR] %s cycle %0d: expected %0h, actual %0h",
					name, n, exp_led, led_o[1:0]);
			end
			if (n == 1 || n == gap + 1)
				drive_line(sel, 1'b1);
			if (gap > 0 && n == gap)
				drive_line(sel, 1'b0);
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		void'($urandom(28));
		rst1 = 1'b0;
		uart_rxd_i = 1'b1;
		uart_txd_i = 1'b1;
		// Inputs set so the synchronizer reset has something to hide
		btn_i = 5'h15;
		dipsw_i = 8'hA5;
		gpio_we_i = 1'b0;
		gpio_dat_i = '0;
		repeat (10) @(negedge sys_clk);

		check_val("reset sys_rst", 1, sys_rst_o);
		check_val("reset flash_rst_n", 0, flash_rst_n_o);
		check_val("reset led", 0, led_o);
		check_val("reset gpio pins", 0, gpio_pins());
		check_val("reset irq", 0, gpio_irq_o);
		check_val("reset gpio_in", 0, gpio_in_o);

		release_and_measure("reset_release");

		// Write and then hold with the strobe low and other data on the bus
		load_table();
		for (int i = 0; i < TABLE_LEN; i++) begin
			gpio_we_i = 1'b1;
			gpio_dat_i = tbl_dat[i];
			@(negedge sys_clk);
			gpio_we_i = 1'b0;
			gpio_dat_i = ~tbl_dat[i];
			check_pins("gpio_write", i);
			@(negedge sys_clk);
			check_pins("gpio_hold", i);
		end

		input_change_test();

		activity_test("rx_single", RX_LED, 0);
		activity_test("rx_extend", RX_LED, 100);
		activity_test("tx_extend", TX_LED, 100);

		debounce_test();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
design/board_pkg.sv
design/timer_if.sv
design/hold_timer.sv
design/reset_sequencer.sv
design/activity_stretcher.sv
design/gpio_port.sv
design/board_ctrl_top.sv
sim/tb_board_ctrl.sv
